// ==== bootrom_image.svh ====
// Boot ROM image

localparam tile_pkg::data_t BOOTROM_IMAGE [16] = '{
   32'h1800_0000,   // l.movhi r0,0
   32'h1820_0000,   // l.movhi r1,0
   32'ha821_1000,   // Stack at top of local memory
   32'h1860_e000,   // External window base
   32'h8483_0000,
   32'hbc04_0000,
   32'h1000_0004,
   32'h1500_0000,
   32'h1880_0000,
   32'ha884_0100,
   32'h4400_2000,   // Jump into local memory
   32'h1500_0000,
   32'h0000_0000,   // Branch to self
   32'h1500_0000,
   32'hdead_c0de,
   32'h0b00_7115
};

// ==== tile_pkg.sv ====
// Compute tile bus definitions
`default_nettype none

package tile_pkg;

   // Bus population
   localparam int NUM_MASTERS = 3;           // Instruction, data, network adapter
   localparam int LMEM_BANKS  = 4;
   localparam int BANK_WORDS  = 256;         // 1 KiB per bank

   // Local memory window, bank in bits 11:10 and word in bits 9:2
   localparam logic [31:0] LMEM_BASE  = 32'h0000_0000;
   localparam logic [31:0] LMEM_LIMIT = 32'h0000_0FFF;

   // Top nibble matches for the 256 MiB windows
   localparam logic [3:0] EXT_MATCH  = 4'he;  // External memory port
   localparam logic [3:0] BOOT_MATCH = 4'hf;  // Boot ROM, 16 words aliased

   // Bus vectors
   typedef logic [31:0] addr_t;
   typedef logic [31:0] data_t;
   typedef logic [3:0]  sel_t;               // One bit per byte lane

   // One bit per master, used for cyc, stb, we, grant, ack and err
   typedef logic [NUM_MASTERS-1:0] master_vec_t;

   // Local memory indices
   typedef logic [1:0] bank_idx_t;
   typedef logic [7:0] word_idx_t;

   // Arbiter FSM
   typedef enum logic [0:0] {
      ARB_IDLE,                               // No grant, waiting for cyc
      ARB_BUSY                                // Grant held until cyc drops
   } arb_state_t;

endpackage

`default_nettype wire

// ==== tile_bus_arbiter.sv ====
// Round-robin bus arbiter
`timescale 1ns/10ps
`default_nettype none

module tile_bus_arbiter (
   input  wire                  clk,
   input  wire                  rst_n_i,
   input  wire tile_pkg::master_vec_t m_cyc_i,
   output tile_pkg::master_vec_t grant_o,
   output logic                 bus_cyc_o
);

   tile_pkg::arb_state_t  state_q;
   tile_pkg::master_vec_t grant_q;
   tile_pkg::master_vec_t last_q;      // One-hot, most recent grant
   tile_pkg::master_vec_t next_grant;

   // Search starts at the master after the last one granted
   always_comb begin
      int base;
      int idx;
      base = 0;
      for (int k = 0; k < tile_pkg::NUM_MASTERS; k++) begin
         if (last_q[k]) begin
            base = k;
         end
      end
      next_grant = '0;
      for (int k = 1; k <= tile_pkg::NUM_MASTERS; k++) begin
         idx = (base + k) % tile_pkg::NUM_MASTERS;
         if (next_grant == '0 && m_cyc_i[idx]) begin
            next_grant[idx] = 1'b1;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= tile_pkg::ARB_IDLE;
         grant_q <= '0;
         last_q  <= tile_pkg::master_vec_t'(1) << (tile_pkg::NUM_MASTERS - 1);  // Master 0 first
      end else begin
         case (state_q)
            tile_pkg::ARB_IDLE: begin
               if (|m_cyc_i) begin
                  grant_q <= next_grant;
                  last_q  <= next_grant;
                  state_q <= tile_pkg::ARB_BUSY;
               end
            end
            tile_pkg::ARB_BUSY: begin
               if (!bus_cyc_o) begin           // Owner ended its cycle
                  grant_q <= '0;
                  state_q <= tile_pkg::ARB_IDLE;
               end
            end
            default: state_q <= tile_pkg::ARB_IDLE;
         endcase
      end
   end

   assign grant_o   = grant_q;
   assign bus_cyc_o = |(m_cyc_i & grant_q);

   a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
      $onehot0(grant_o))
      else $error("Arbiter grant is not one-hot");

   // Ownership is kept for the whole Wishbone cycle
   a_grant_held: assert property (@(posedge clk) disable iff (!rst_n_i)
      bus_cyc_o |=> $stable(grant_o))
      else $error("Arbiter grant changed during an open cycle");

endmodule

`default_nettype wire

// ==== tile_addr_decoder.sv ====
// Shared bus address decoder
`timescale 1ns/10ps
`default_nettype none

module tile_addr_decoder (
   input  wire tile_pkg::addr_t        bus_adr_i,
   input  wire                         bus_stb_i,
   output logic [tile_pkg::LMEM_BANKS-1:0] bank_stb_o,
   output logic                        rom_stb_o,
   output logic                        ext_stb_o,
   output logic                        unmapped_stb_o
);

   logic                lmem_hit;
   logic                ext_hit;
   logic                boot_hit;
   tile_pkg::bank_idx_t bank_sel;

   // Unsigned window check, also valid for a nonzero base
   assign lmem_hit = (bus_adr_i - tile_pkg::LMEM_BASE) <=
                     (tile_pkg::LMEM_LIMIT - tile_pkg::LMEM_BASE);
   assign ext_hit  = (bus_adr_i[31:28] == tile_pkg::EXT_MATCH);
   assign boot_hit = (bus_adr_i[31:28] == tile_pkg::BOOT_MATCH);
   assign bank_sel = bus_adr_i[11:10];    // Banks interleaved per KiB

   always_comb begin
      bank_stb_o = '0;
      if (bus_stb_i && lmem_hit) begin
         bank_stb_o[bank_sel] = 1'b1;
      end
   end

   assign rom_stb_o      = bus_stb_i & boot_hit;
   assign ext_stb_o      = bus_stb_i & ext_hit;
   assign unmapped_stb_o = bus_stb_i & ~(lmem_hit | ext_hit | boot_hit);

   // Windows must not overlap in the map
   always_comb begin
      if (!$isunknown({bank_stb_o, rom_stb_o, ext_stb_o, unmapped_stb_o})) begin
         a_one_target: assert final
            ($onehot0({bank_stb_o, rom_stb_o, ext_stb_o, unmapped_stb_o}))
            else $error("Address decoder selected more than one target");
      end
   end

endmodule

`default_nettype wire

// ==== tile_sram_bank.sv ====
// Local memory bank with Wishbone slave
`timescale 1ns/10ps
`default_nettype none

module tile_sram_bank (
   input  wire                      clk,
   input  wire                      rst_n_i,
   input  wire                      stb_i,
   input  wire                      we_i,
   input  wire tile_pkg::word_idx_t word_i,
   input  wire tile_pkg::sel_t      sel_i,
   input  wire tile_pkg::data_t     dat_i,
   output logic                     ack_o,
   output tile_pkg::data_t          dat_o
);

   tile_pkg::data_t mem [tile_pkg::BANK_WORDS];
   logic            stb_q;
   logic            req;

   // Only the first cycle of a select is a new access
   assign req = stb_i & ~stb_q;

   always_ff @(posedge clk) begin
      if (req && we_i) begin
         for (int b = 0; b < $bits(tile_pkg::sel_t); b++) begin
            if (sel_i[b]) begin
               mem[word_i][8*b +: 8] <= dat_i[8*b +: 8];  // Byte lane write
            end
         end
      end
      if (req && !we_i) begin
         dat_o <= mem[word_i];                         // Registered read
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         stb_q <= 1'b0;
         ack_o <= 1'b0;
      end else begin
         stb_q <= stb_i;
         ack_o <= req;                                 // Single-cycle pulse
      end
   end

endmodule

`default_nettype wire

// ==== tile_bootrom.sv ====
// Boot ROM with Wishbone slave
`timescale 1ns/10ps
`default_nettype none

module tile_bootrom (
   input  wire                  clk,
   input  wire                  rst_n_i,
   input  wire                  stb_i,
   input  wire                  we_i,
   input  wire tile_pkg::addr_t adr_i,
   output logic                 ack_o,
   output logic                 err_o,
   output tile_pkg::data_t      dat_o
);

   `include "bootrom_image.svh"

   logic stb_q;
   logic req;

   assign req = stb_i & ~stb_q;

   always_ff @(posedge clk) begin
      if (req) begin
         dat_o <= BOOTROM_IMAGE[adr_i[5:2]];  // Aliased every 64 bytes
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         stb_q <= 1'b0;
         ack_o <= 1'b0;
         err_o <= 1'b0;
      end else begin
         stb_q <= stb_i;
         ack_o <= req & ~we_i;
         err_o <= req & we_i;                 // Writes are refused
      end
   end

endmodule

`default_nettype wire

// ==== tile_resp_mux.sv ====
// Slave response merge and master steering
`timescale 1ns/10ps
`default_nettype none

module tile_resp_mux (
   input  wire                         clk,
   input  wire                         rst_n_i,
   input  wire tile_pkg::master_vec_t  grant_i,
   input  wire                         unmapped_stb_i,
   input  wire [tile_pkg::LMEM_BANKS-1:0] bank_ack_i,
   input  wire tile_pkg::data_t        bank_dat_i [tile_pkg::LMEM_BANKS],
   input  wire                         rom_ack_i,
   input  wire                         rom_err_i,
   input  wire tile_pkg::data_t        rom_dat_i,
   input  wire                         ext_ack_i,
   input  wire                         ext_err_i,
   input  wire tile_pkg::data_t        ext_dat_i,
   output tile_pkg::master_vec_t       m_ack_o,
   output tile_pkg::master_vec_t       m_err_o,
   output tile_pkg::data_t             m_dat_o
);

   logic unmapped_q;
   logic unmapped_err;
   logic ack;
   logic err;

   // Unmapped error follows the same timing as a local slave
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         unmapped_q   <= 1'b0;
         unmapped_err <= 1'b0;
      end else begin
         unmapped_q   <= unmapped_stb_i;
         unmapped_err <= unmapped_stb_i & ~unmapped_q;
      end
   end

   assign ack = (|bank_ack_i) | rom_ack_i | ext_ack_i;
   assign err = unmapped_err | rom_err_i | ext_err_i;

   always_comb begin
      m_dat_o = '0;
      if (ext_ack_i) begin
         m_dat_o = ext_dat_i;
      end
      if (rom_ack_i) begin
         m_dat_o = rom_dat_i;
      end
      for (int b = 0; b < tile_pkg::LMEM_BANKS; b++) begin
         if (bank_ack_i[b]) begin
            m_dat_o = bank_dat_i[b];
         end
      end
   end

   // Only the owner of the cycle sees the response
   assign m_ack_o = grant_i & {tile_pkg::NUM_MASTERS{ack}};
   assign m_err_o = grant_i & {tile_pkg::NUM_MASTERS{err}};

   a_ack_err_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
      !(ack && err))
      else $error("Bus ack and err raised together");

endmodule

`default_nettype wire

// ==== compute_tile_bus.sv ====
// Compute tile shared bus top level
`timescale 1ns/10ps
`default_nettype none

module compute_tile_bus (
   input  wire                        clk,
   input  wire                        rst_n_i,

   // Bus masters
   input  wire tile_pkg::master_vec_t m_cyc_i,
   input  wire tile_pkg::master_vec_t m_stb_i,
   input  wire tile_pkg::master_vec_t m_we_i,
   input  wire tile_pkg::addr_t       m_adr_i [tile_pkg::NUM_MASTERS],
   input  wire tile_pkg::data_t       m_dat_i [tile_pkg::NUM_MASTERS],
   input  wire tile_pkg::sel_t        m_sel_i [tile_pkg::NUM_MASTERS],
   output tile_pkg::master_vec_t      m_ack_o,
   output tile_pkg::master_vec_t      m_err_o,
   output tile_pkg::data_t            m_dat_o,

   // External memory port
   output logic                       wb_ext_cyc_o,
   output logic                       wb_ext_stb_o,
   output logic                       wb_ext_we_o,
   output tile_pkg::addr_t            wb_ext_adr_o,
   output tile_pkg::data_t            wb_ext_dat_o,
   output tile_pkg::sel_t             wb_ext_sel_o,
   input  wire                        wb_ext_ack_i,
   input  wire                        wb_ext_err_i,
   input  wire tile_pkg::data_t       wb_ext_dat_i
);

   tile_pkg::master_vec_t grant;
   logic                  bus_cyc;
   logic                  bus_stb_m;
   logic                  bus_stb;
   logic                  bus_we;
   tile_pkg::addr_t       bus_adr;
   tile_pkg::data_t       bus_dat;
   tile_pkg::sel_t        bus_sel;
   tile_pkg::word_idx_t   bus_word;

   logic [tile_pkg::LMEM_BANKS-1:0] bank_stb;
   logic [tile_pkg::LMEM_BANKS-1:0] bank_ack;
   tile_pkg::data_t                 bank_dat [tile_pkg::LMEM_BANKS];
   logic                            rom_stb;
   logic                            rom_ack;
   logic                            rom_err;
   tile_pkg::data_t                 rom_dat;
   logic                            ext_stb;
   logic                            unmapped_stb;

   tile_bus_arbiter u_arbiter (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .m_cyc_i   (m_cyc_i),
      .grant_o   (grant),
      .bus_cyc_o (bus_cyc)
   );

   // Granted master drives the shared bus
   always_comb begin
      bus_stb_m = 1'b0;
      bus_we    = 1'b0;
      bus_adr   = '0;
      bus_dat   = '0;
      bus_sel   = '0;
      for (int m = 0; m < tile_pkg::NUM_MASTERS; m++) begin
         if (grant[m]) begin
            bus_stb_m = m_stb_i[m];
            bus_we    = m_we_i[m];
            bus_adr   = m_adr_i[m];
            bus_dat   = m_dat_i[m];
            bus_sel   = m_sel_i[m];
         end
      end
   end

   assign bus_stb  = bus_cyc & bus_stb_m;      // stb only counts inside cyc
   assign bus_word = bus_adr[9:2];

   tile_addr_decoder u_decoder (
      .bus_adr_i      (bus_adr),
      .bus_stb_i      (bus_stb),
      .bank_stb_o     (bank_stb),
      .rom_stb_o      (rom_stb),
      .ext_stb_o      (ext_stb),
      .unmapped_stb_o (unmapped_stb)
   );

   for (genvar b = 0; b < tile_pkg::LMEM_BANKS; b++) begin : gen_lmem_bank
      tile_sram_bank u_bank (
         .clk     (clk),
         .rst_n_i (rst_n_i),
         .stb_i   (bank_stb[b]),
         .we_i    (bus_we),
         .word_i  (bus_word),
         .sel_i   (bus_sel),
         .dat_i   (bus_dat),
         .ack_o   (bank_ack[b]),
         .dat_o   (bank_dat[b])
      );
   end

   tile_bootrom u_bootrom (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .stb_i   (rom_stb),
      .we_i    (bus_we),
      .adr_i   (bus_adr),
      .ack_o   (rom_ack),
      .err_o   (rom_err),
      .dat_o   (rom_dat)
   );

   // External window leaves the tile unchanged
   assign wb_ext_cyc_o = ext_stb;
   assign wb_ext_stb_o = ext_stb;
   assign wb_ext_we_o  = bus_we;
   assign wb_ext_adr_o = bus_adr;
   assign wb_ext_dat_o = bus_dat;
   assign wb_ext_sel_o = bus_sel;

   tile_resp_mux u_resp_mux (
      .clk            (clk),
      .rst_n_i        (rst_n_i),
      .grant_i        (grant),
      .unmapped_stb_i (unmapped_stb),
      .bank_ack_i     (bank_ack),
      .bank_dat_i     (bank_dat),
      .rom_ack_i      (rom_ack),
      .rom_err_i      (rom_err),
      .rom_dat_i      (rom_dat),
      .ext_ack_i      (wb_ext_ack_i),
      .ext_err_i      (wb_ext_err_i),
      .ext_dat_i      (wb_ext_dat_i),
      .m_ack_o        (m_ack_o),
      .m_err_o        (m_err_o),
      .m_dat_o        (m_dat_o)
   );

endmodule

`default_nettype wire

// ==== tb_tile_model.svh ====
// Testbench reference model

`include "bootrom_image.svh"

typedef enum logic [1:0] {
   CLS_LMEM,                        // Local memory banks
   CLS_ROM,                         // Boot ROM window
   CLS_EXT,                         // External memory port
   CLS_NONE                         // Outside every window
} addr_class_t;

tile_pkg::data_t lmem_model [tile_pkg::LMEM_BANKS*tile_pkg::BANK_WORDS];
logic [3:0]      lmem_known [tile_pkg::LMEM_BANKS*tile_pkg::BANK_WORDS];  // Written byte lanes

function automatic logic [31:0] lcg_next(input logic [31:0] state);
   return state * 32'd1664525 + 32'd1013904223;
endfunction

// Address map of the tile as seen from a master
function automatic addr_class_t classify(input tile_pkg::addr_t adr);
   if (adr[31:12] == 20'h0) return CLS_LMEM;   // 4 KiB at address zero
   if (adr[31:28] == 4'he) return CLS_EXT;
   if (adr[31:28] == 4'hf) return CLS_ROM;
   return CLS_NONE;
endfunction

// Bank in bits 11:10 and word in bits 9:2 give one flat index
function automatic int lmem_index(input tile_pkg::addr_t adr);
   return int'(adr[11:2]);
endfunction

function automatic tile_pkg::data_t known_mask(input tile_pkg::addr_t adr);
   tile_pkg::data_t mask;
   mask = '0;
   for (int b = 0; b < 4; b++) begin
      if (lmem_known[lmem_index(adr)][b]) mask[8*b +: 8] = 8'hff;
   end
   return mask;
endfunction

task automatic model_write(input tile_pkg::addr_t adr, input tile_pkg::data_t dat,
                           input tile_pkg::sel_t sel);
   for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
         lmem_model[lmem_index(adr)][8*b +: 8] = dat[8*b +: 8];  // Byte merge
         lmem_known[lmem_index(adr)][b]        = 1'b1;
      end
   end
endtask

function automatic tile_pkg::data_t rom_word(input tile_pkg::addr_t adr);
   return BOOTROM_IMAGE[adr[5:2]];  // 16 words aliased
endfunction

// Read data of the external responder, a mix of the full address
function automatic tile_pkg::data_t ext_read_value(input tile_pkg::addr_t adr);
   return {adr[15:0], ~adr[31:16]} ^ 32'h3c5a_96e1;
endfunction

// ==== tb_compute_tile_bus.sv ====
// Compute tile bus testbench
`timescale 1ns/10ps
`default_nettype none

module tb_compute_tile_bus;

   localparam int          TXN_PER_MASTER = 300;
   localparam int          TIMEOUT_CYCLES = tile_pkg::NUM_MASTERS * TXN_PER_MASTER * 8 + 100;
   localparam logic [31:0] LCG_SEED       = 32'he8a5;
   localparam time         DRIVE_DLY      = 2;

   logic                  clk;
   logic                  rst_n_i;
   tile_pkg::master_vec_t m_cyc;
   tile_pkg::master_vec_t m_stb;
   tile_pkg::master_vec_t m_we;
   tile_pkg::addr_t       m_adr [tile_pkg::NUM_MASTERS];
   tile_pkg::data_t       m_dat [tile_pkg::NUM_MASTERS];
   tile_pkg::sel_t        m_sel [tile_pkg::NUM_MASTERS];
   tile_pkg::master_vec_t m_ack;
   tile_pkg::master_vec_t m_err;
   tile_pkg::data_t       m_rdat;
   logic                  wb_ext_cyc;
   logic                  wb_ext_stb;
   logic                  wb_ext_we;
   tile_pkg::addr_t       wb_ext_adr;
   tile_pkg::data_t       wb_ext_dat;
   tile_pkg::sel_t        wb_ext_sel;
   logic                  wb_ext_ack;
   logic                  wb_ext_err;
   tile_pkg::data_t       wb_ext_rdat;

   logic [31:0]           rng_state [tile_pkg::NUM_MASTERS+1];  // Last one for the responder
   tile_pkg::master_vec_t cyc_at_edge;
   tile_pkg::master_vec_t resp;
   int                    cycle_cnt;
   tile_pkg::addr_t       ext_seen_adr;
   tile_pkg::data_t       ext_seen_dat;
   tile_pkg::sel_t        ext_seen_sel;
   logic                  ext_seen_we;

   `include "tb_tile_model.svh"

   compute_tile_bus UUT (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .m_cyc_i      (m_cyc),
      .m_stb_i      (m_stb),
      .m_we_i       (m_we),
      .m_adr_i      (m_adr),
      .m_dat_i      (m_dat),
      .m_sel_i      (m_sel),
      .m_ack_o      (m_ack),
      .m_err_o      (m_err),
      .m_dat_o      (m_rdat),
      .wb_ext_cyc_o (wb_ext_cyc),
      .wb_ext_stb_o (wb_ext_stb),
      .wb_ext_we_o  (wb_ext_we),
      .wb_ext_adr_o (wb_ext_adr),
      .wb_ext_dat_o (wb_ext_dat),
      .wb_ext_sel_o (wb_ext_sel),
      .wb_ext_ack_i (wb_ext_ack),
      .wb_ext_err_i (wb_ext_err),
      .wb_ext_dat_i (wb_ext_rdat)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic abort_run();
      $display("TB FAILED");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp)
      else begin
         $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic draw(input int idx, output logic [31:0] r);
      logic [31:0] s1;
      s1             = lcg_next(rng_state[idx]);
      rng_state[idx] = lcg_next(s1);
      r              = {s1[31:16], rng_state[idx][31:16]};  // Upper halves mix better
   endtask

   task automatic pick_address(input int m, output tile_pkg::addr_t adr);
      logic [31:0] r;
      logic [3:0]  nib;
      draw(m, r);
      nib = 4'd1 + 4'(r[27:24] % 13);                     // Top nibble 1 to D
      case (r[31:29])
         3'd5:    adr = {4'hf, r[27:2], 2'b00};
         3'd6:    adr = {4'he, r[27:2], 2'b00};
         3'd7:    adr = {nib, 12'h000, r[15:10], r[9:2] & 8'hc7, 2'b00};  // Aliases local words
         default: adr = {20'h0, r[11:10], r[9:2] & 8'hc7, 2'b00};  // 32 words per bank
      endcase
   endtask

   task automatic check_response(input int m, input tile_pkg::addr_t adr,
                                 input tile_pkg::data_t dat, input tile_pkg::sel_t sel,
                                 input logic we, input addr_class_t cls);
      logic            exp_err;
      tile_pkg::data_t mask;
      exp_err = (cls == CLS_NONE) || (cls == CLS_ROM && we);
      check_value($sformatf("m_ack_o[%0d]", m), m_ack[m], !exp_err);
      check_value($sformatf("m_err_o[%0d]", m), m_err[m], exp_err);
      case (cls)
         CLS_LMEM: begin
            if (we) begin
               model_write(adr, dat, sel);
            end else begin
               mask = known_mask(adr);                     // Never written lanes are unknown
               check_value("m_dat_o", m_rdat & mask, lmem_model[lmem_index(adr)] & mask);
            end
         end
         CLS_ROM: if (!we) check_value("m_dat_o", m_rdat, rom_word(adr));
         CLS_EXT: begin
            check_value("wb_ext_adr_o", ext_seen_adr, adr);
            check_value("wb_ext_we_o", ext_seen_we, we);
            check_value("wb_ext_sel_o", ext_seen_sel, sel);
            if (we) check_value("wb_ext_dat_o", ext_seen_dat, dat);
            else    check_value("m_dat_o", m_rdat, ext_read_value(adr));
         end
         default: ;
      endcase
   endtask

   task automatic run_master(input int m);
      logic [31:0]     r;
      tile_pkg::addr_t adr;
      tile_pkg::data_t dat;
      tile_pkg::sel_t  sel;
      logic            we;
      addr_class_t     cls;
      int              gap;
      int              waited;
      logic            idle_start;
      logic            alone;
      logic            done;
      for (int t = 0; t < TXN_PER_MASTER; t++) begin
         pick_address(m, adr);
         draw(m, dat);
         draw(m, r);
         we  = r[4];
         sel = we ? r[3:0] : 4'hf;
         gap = 1 + r[6:5];                                  // At least one idle cycle
         cls = classify(adr);
         repeat (gap) @(posedge clk);
         #DRIVE_DLY;
         idle_start = (cyc_at_edge == '0);                  // No cycle open last clock
         m_adr[m] = adr;
         m_dat[m] = dat;
         m_sel[m] = sel;
         m_we[m]  = we;
         m_cyc[m] = 1'b1;
         m_stb[m] = 1'b1;
         waited = 0;
         alone  = 1'b0;
         done   = 1'b0;
         while (!done) begin
            @(negedge clk);
            if (waited == 0) alone = (m_cyc == (tile_pkg::master_vec_t'(1) << m));
            done = m_ack[m] | m_err[m];
            if (!done) waited++;
         end
         check_response(m, adr, dat, sel, we, cls);
         if (idle_start && alone && cls != CLS_EXT) begin
            check_value($sformatf("ack latency of master %0d", m), waited, 2);
         end
         @(posedge clk);
         #DRIVE_DLY;
         m_cyc[m] = 1'b0;
         m_stb[m] = 1'b0;
      end
   endtask

   // External slave with a random wait of 0 to 3 cycles
   task automatic serve_external();
      logic [31:0] r;
      int          delay;
      @(negedge clk);
      if (wb_ext_cyc && wb_ext_stb) begin
         ext_seen_adr = wb_ext_adr;
         ext_seen_dat = wb_ext_dat;
         ext_seen_sel = wb_ext_sel;
         ext_seen_we  = wb_ext_we;
         draw(tile_pkg::NUM_MASTERS, r);
         delay = r[1:0];
         repeat (delay) @(posedge clk);
         @(posedge clk);
         #DRIVE_DLY;
         wb_ext_ack  = 1'b1;
         wb_ext_rdat = ext_seen_we ? '0 : ext_read_value(ext_seen_adr);
         @(posedge clk);
         #DRIVE_DLY;
         wb_ext_ack  = 1'b0;
         wb_ext_rdat = '0;
      end
   endtask

   initial begin
      forever serve_external();
   end

   always @(posedge clk) cyc_at_edge <= m_cyc;

   // Responses only go to the one master with an open cycle
   always @(negedge clk) begin
      if (rst_n_i) begin
         resp = m_ack | m_err;
         assert ((resp & ~m_cyc) == '0)
         else begin
            $display("Response at %0t ns reached a master without an open cycle", $time);
            abort_run();
         end
         assert ((resp & (resp - 1'b1)) == '0)
         else begin
            $display("Response at %0t ns reached more than one master", $time);
            abort_run();
         end
      end
   end

   initial begin
      cycle_cnt = 0;
      forever begin
         @(posedge clk);
         cycle_cnt++;
         assert (cycle_cnt < TIMEOUT_CYCLES)
         else begin
            $display("Timeout after %0d cycles with transactions still open", cycle_cnt);
            abort_run();
         end
      end
   end

   initial begin
      rst_n_i     = 1'b0;
      m_cyc       = '0;
      m_stb       = '0;
      m_we        = '0;
      wb_ext_ack  = 1'b0;
      wb_ext_err  = 1'b0;
      wb_ext_rdat = '0;
      for (int m = 0; m < tile_pkg::NUM_MASTERS; m++) begin
         m_adr[m] = '0;
         m_dat[m] = '0;
         m_sel[m] = '0;
      end
      for (int i = 0; i <= tile_pkg::NUM_MASTERS; i++) rng_state[i] = LCG_SEED + i;
      for (int i = 0; i < tile_pkg::LMEM_BANKS*tile_pkg::BANK_WORDS; i++) begin
         lmem_known[i] = 4'h0;
         lmem_model[i] = '0;
      end
      repeat (10) @(posedge clk);
      #DRIVE_DLY;
      check_value("m_ack_o", m_ack, 0);                     // Quiet bus in reset
      check_value("m_err_o", m_err, 0);
      check_value("wb_ext_cyc_o", wb_ext_cyc, 0);
      check_value("wb_ext_stb_o", wb_ext_stb, 0);
      rst_n_i = 1'b1;
      fork
         run_master(0);
         run_master(1);
         run_master(2);
      join
      repeat (4) @(posedge clk);
      $display("TB PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== compute_tile_bus.f ====
+incdir+.
tile_pkg.sv
tile_bus_arbiter.sv
tile_addr_decoder.sv
tile_sram_bank.sv
tile_bootrom.sv
tile_resp_mux.sv
compute_tile_bus.sv
tb_compute_tile_bus.sv
